/* rtl/lut_pkg.sv */
package lut_pkg;

   localparam int GEN_W      = 16;  // Address generator fields
   localparam int BUS_ADDR_W = 32;
   localparam int BUS_DATA_W = 32;  // Also the table word width
   localparam int LEN_W      = 8;

   // Load configuration, held stable while a load is in progress
   typedef struct packed {
      logic [BUS_ADDR_W-1:0] ext_addr;
      logic [GEN_W-1:0]      iter;
      logic [GEN_W-1:0]      per;
      logic [GEN_W-1:0]      incr;
      logic [GEN_W-1:0]      shift;
      logic [LEN_W-1:0]      length;  // Must equal iter * per
      logic                  ping_pong;
   } lut_cfg_t;

   // Unit side of the data bus
   typedef struct packed {
      logic                  valid;  // Unit can take a beat
      logic [BUS_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } bus_req_t;

   // Bus side of the data bus
   typedef struct packed {
      logic                  ready;  // Beat present
      logic [BUS_DATA_W-1:0] rdata;
      logic                  last;
   } bus_rsp_t;

   typedef enum logic {
      LOAD_IDLE,
      LOAD_BUSY
   } load_state_e;

endpackage

/* rtl/lut_addr_gen.sv */
module lut_addr_gen
   import lut_pkg::*;
#(
   parameter int TABLE_ADDR_W = 8
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run_i,
   input  lut_cfg_t                cfg_i,
   input  logic                    ready_i,
   output logic                    valid_o,
   output logic [TABLE_ADDR_W-1:0] addr_o,
   output logic                    done_o
);

   logic             busy_q;
   logic             done_q;
   logic [GEN_W-1:0] per_cnt_q;   // Position inside the period
   logic [GEN_W-1:0] iter_cnt_q;  // Completed periods
   logic [GEN_W-1:0] base_q;      // Start of the current period
   logic [GEN_W-1:0] addr_q;
   logic             step;
   logic             per_end;
   logic             iter_end;
   logic             empty_cfg;

   assign step      = busy_q & ready_i;
   assign per_end   = (per_cnt_q == cfg_i.per - GEN_W'(1));
   assign iter_end  = (iter_cnt_q == cfg_i.iter - GEN_W'(1));
   assign empty_cfg = (cfg_i.iter == '0) || (cfg_i.per == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q     <= 1'b0;
         done_q     <= 1'b1;
         per_cnt_q  <= '0;
         iter_cnt_q <= '0;
         base_q     <= '0;
         addr_q     <= '0;
      end else if (run_i) begin
         busy_q     <= ~empty_cfg;
         done_q     <= empty_cfg;  // Nothing to generate
         per_cnt_q  <= '0;
         iter_cnt_q <= '0;
         base_q     <= '0;
         addr_q     <= '0;
      end else if (step) begin
         if (per_end) begin
            // Period boundary moves the base by shift
            per_cnt_q  <= '0;
            iter_cnt_q <= iter_cnt_q + GEN_W'(1);
            base_q     <= base_q + cfg_i.shift;
            addr_q     <= base_q + cfg_i.shift;
            if (iter_end) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end else begin
            per_cnt_q <= per_cnt_q + GEN_W'(1);
            addr_q    <= addr_q + cfg_i.incr;
         end
      end
   end

   assign valid_o = busy_q;
   assign addr_o  = addr_q[TABLE_ADDR_W-1:0];
   assign done_o  = done_q;

   // An address is never offered once the sequence has finished
   assert property (@(posedge clk) disable iff (rst) !(valid_o && done_o))
      else $error("lut_addr_gen: valid_o high while done_o");

endmodule

/* rtl/lut_beat_join.sv */
module lut_beat_join
   import lut_pkg::*;
#(
   parameter int TABLE_ADDR_W = 8
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    first_valid_i,
   input  logic [TABLE_ADDR_W-1:0] first_addr_i,
   output logic                    first_ready_o,
   input  bus_rsp_t                rsp_i,
   output logic                    take_o,
   output logic                    wr_en_o,
   output logic [TABLE_ADDR_W-1:0] wr_addr_o,
   output logic [BUS_DATA_W-1:0]   wr_data_o
);

   logic match;  // Address pending and beat present

   assign match         = first_valid_i & rsp_i.ready;
   assign first_ready_o = match;
   assign take_o        = first_valid_i;  // Bus may hand over a beat only with an address

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en_o <= 1'b0;
      end else begin
         wr_en_o <= match;  // Result side never stalls
      end
   end

   always_ff @(posedge clk) begin
      if (match) begin
         wr_addr_o <= first_addr_i;
         wr_data_o <= rsp_i.rdata;
      end
   end

   // Exactly one write per transfer, carrying that beat's data
   assert property (@(posedge clk) disable iff (rst)
      match |=> wr_en_o && (wr_data_o == $past(rsp_i.rdata)))
      else $error("lut_beat_join: transfer without matching write");

endmodule

/* rtl/lut_lane_select.sv */
module lut_lane_select
   import lut_pkg::*;
#(
   parameter int ENTRY_W = 16,
   parameter int DATA_W  = 32,
   localparam int LANES  = BUS_DATA_W / ENTRY_W,
   localparam int SEL_W  = (LANES > 1) ? $clog2(LANES) : 1
) (
   input  logic [SEL_W-1:0]      sel_i,
   input  logic [BUS_DATA_W-1:0] word_i,
   output logic [DATA_W-1:0]     entry_o
);

   logic [ENTRY_W-1:0] lanes [LANES];

   // Lane 0 sits in the low bits of the word
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      assign lanes[i] = word_i[i*ENTRY_W +: ENTRY_W];
   end

   assign entry_o = DATA_W'(lanes[sel_i]);  // Zero-extended

endmodule

/* rtl/lut_table_ram.sv */
module lut_table_ram
   import lut_pkg::*;
#(
   parameter int TABLE_ADDR_W = 8
) (
   input  logic                    clk,
   input  logic [TABLE_ADDR_W-1:0] rd_addr_i,
   output logic [BUS_DATA_W-1:0]   rd_data_o,
   input  logic                    wr_en_i,
   input  logic [TABLE_ADDR_W-1:0] wr_addr_i,
   input  logic [BUS_DATA_W-1:0]   wr_data_i
);

   localparam int DEPTH = 2 ** TABLE_ADDR_W;

   logic [BUS_DATA_W-1:0] mem [DEPTH];

   // Read port returns old contents on a same-address write
   always_ff @(posedge clk) begin
      rd_data_o <= mem[rd_addr_i];
   end

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

endmodule

/* rtl/lut_reader.sv */
module lut_reader
   import lut_pkg::*;
#(
   parameter int DATA_W       = 32,
   parameter int ENTRY_W      = 16,
   parameter int TABLE_ADDR_W = 8,
   localparam int LANES       = BUS_DATA_W / ENTRY_W,
   localparam int SEL_W       = (LANES > 1) ? $clog2(LANES) : 1
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run_i,
   input  logic                    disable_i,
   input  lut_cfg_t                cfg_i,
   input  logic [DATA_W-1:0]       in_i,
   output logic [DATA_W-1:0]       out_o,
   output logic                    done_o,
   output bus_req_t                bus_req_o,
   input  bus_rsp_t                bus_rsp_i,
   output logic [TABLE_ADDR_W-1:0] tbl_rd_addr_o,
   input  logic [BUS_DATA_W-1:0]   tbl_rd_data_i,
   output logic                    tbl_wr_en_o,
   output logic [TABLE_ADDR_W-1:0] tbl_wr_addr_o,
   output logic [BUS_DATA_W-1:0]   tbl_wr_data_o
);

   load_state_e             state_q;
   logic                    start;
   logic                    bank_q;     // Bank being loaded
   logic                    fin_q;      // Last beat taken last cycle
   logic [BUS_ADDR_W-1:0]   burst_addr_q;
   logic [SEL_W-1:0]        sel_0_q;    // Aligned with tbl_rd_addr_o
   logic [SEL_W-1:0]        sel_1_q;    // Aligned with tbl_rd_data_i
   logic [TABLE_ADDR_W-1:0] rd_addr_d;
   logic                    gen_valid;
   logic                    gen_ready;
   logic [TABLE_ADDR_W-1:0] gen_addr;
   logic                    gen_done;
   logic                    take;
   logic                    last_xfer;
   logic [TABLE_ADDR_W-1:0] wr_addr;

   assign start     = run_i & ~disable_i;
   assign last_xfer = take & bus_rsp_i.ready & bus_rsp_i.last;

   // Lookup word address, reads go to the bank not being loaded
   always_comb begin
      rd_addr_d = in_i[SEL_W +: TABLE_ADDR_W];
      if (cfg_i.ping_pong) begin
         rd_addr_d[TABLE_ADDR_W-1] = ~bank_q;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tbl_rd_addr_o <= '0;
         sel_0_q       <= '0;
         sel_1_q       <= '0;
      end else begin
         tbl_rd_addr_o <= rd_addr_d;
         sel_0_q       <= in_i[SEL_W-1:0];
         sel_1_q       <= sel_0_q;
      end
   end

   lut_lane_select #(
      .ENTRY_W(ENTRY_W),
      .DATA_W (DATA_W)
   ) u_lane (
      .sel_i  (sel_1_q),
      .word_i (tbl_rd_data_i),
      .entry_o(out_o)
   );

   // Bank swaps on every run in ping-pong mode, disabled runs too
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (run_i) begin
         bank_q <= cfg_i.ping_pong ? ~bank_q : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= LOAD_IDLE;
         fin_q   <= 1'b0;
         done_o  <= 1'b1;
      end else if (start) begin
         state_q <= LOAD_BUSY;
         fin_q   <= 1'b0;
         done_o  <= 1'b0;
      end else begin
         fin_q <= last_xfer;
         if (last_xfer) begin
            state_q <= LOAD_IDLE;
         end
         if (fin_q) begin
            done_o <= 1'b1;  // Final write lands on this edge
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         burst_addr_q <= cfg_i.ext_addr;
      end
   end

   always_comb begin
      bus_req_o.valid = take;
      bus_req_o.addr  = burst_addr_q;
      bus_req_o.len   = cfg_i.length;
   end

   lut_addr_gen #(
      .TABLE_ADDR_W(TABLE_ADDR_W)
   ) u_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (start),
      .cfg_i  (cfg_i),
      .ready_i(gen_ready),
      .valid_o(gen_valid),
      .addr_o (gen_addr),
      .done_o (gen_done)
   );

   lut_beat_join #(
      .TABLE_ADDR_W(TABLE_ADDR_W)
   ) u_join (
      .clk          (clk),
      .rst          (rst),
      .first_valid_i(gen_valid && (state_q == LOAD_BUSY)),
      .first_addr_i (gen_addr),
      .first_ready_o(gen_ready),
      .rsp_i        (bus_rsp_i),
      .take_o       (take),
      .wr_en_o      (tbl_wr_en_o),
      .wr_addr_o    (wr_addr),
      .wr_data_o    (tbl_wr_data_o)
   );

   // Writes go to the bank being loaded
   always_comb begin
      tbl_wr_addr_o = wr_addr;
      if (cfg_i.ping_pong) begin
         tbl_wr_addr_o[TABLE_ADDR_W-1] = bank_q;
      end
   end

   assert property (@(posedge clk) disable iff (rst) tbl_wr_en_o |-> !done_o)
      else $error("lut_reader: table write while done_o high");

   // Burst length and generator count agree, so both finish together
   assert property (@(posedge clk) disable iff (rst) done_o |-> gen_done)
      else $error("lut_reader: load done before generator finished");

endmodule

/* rtl/lut_unit_top.sv */
module lut_unit_top
   import lut_pkg::*;
#(
   parameter int DATA_W       = 32,
   parameter int ENTRY_W      = 16,
   parameter int TABLE_ADDR_W = 8  // Includes the bank bit
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              disable_i,
   input  lut_cfg_t          cfg_i,
   input  logic [DATA_W-1:0] in_i,
   output logic [DATA_W-1:0] out_o,
   output logic              done_o,
   output bus_req_t          bus_req_o,
   input  bus_rsp_t          bus_rsp_i
);

   logic [TABLE_ADDR_W-1:0] tbl_rd_addr;
   logic [BUS_DATA_W-1:0]   tbl_rd_data;
   logic                    tbl_wr_en;
   logic [TABLE_ADDR_W-1:0] tbl_wr_addr;
   logic [BUS_DATA_W-1:0]   tbl_wr_data;

   lut_reader #(
      .DATA_W      (DATA_W),
      .ENTRY_W     (ENTRY_W),
      .TABLE_ADDR_W(TABLE_ADDR_W)
   ) u_reader (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .disable_i    (disable_i),
      .cfg_i        (cfg_i),
      .in_i         (in_i),
      .out_o        (out_o),
      .done_o       (done_o),
      .bus_req_o    (bus_req_o),
      .bus_rsp_i    (bus_rsp_i),
      .tbl_rd_addr_o(tbl_rd_addr),
      .tbl_rd_data_i(tbl_rd_data),
      .tbl_wr_en_o  (tbl_wr_en),
      .tbl_wr_addr_o(tbl_wr_addr),
      .tbl_wr_data_o(tbl_wr_data)
   );

   lut_table_ram #(
      .TABLE_ADDR_W(TABLE_ADDR_W)
   ) u_table (
      .clk      (clk),
      .rd_addr_i(tbl_rd_addr),
      .rd_data_o(tbl_rd_data),
      .wr_en_i  (tbl_wr_en),
      .wr_addr_i(tbl_wr_addr),
      .wr_data_i(tbl_wr_data)
   );

endmodule

/* tb/lut_bus_model.sv */
module lut_bus_model
   import lut_pkg::*;
#(
   parameter int MEM_WORDS = 512  // Power of two, bus addresses wrap
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     stall_i,
   input  bus_req_t req_i,
   output bus_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [BUS_DATA_W-1:0] mem [MEM_WORDS];  // Filled by the testbench
   logic                  active_q;
   logic [BUS_ADDR_W-1:0] base_q;
   logic [LEN_W-1:0]      len_q;
   logic [LEN_W-1:0]      cnt_q;            // Beats already handed over
   logic [IDX_W-1:0]      idx;

   assign idx = IDX_W'(base_q + BUS_ADDR_W'(cnt_q));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         base_q   <= '0;
         len_q    <= '0;
         cnt_q    <= '0;
      end else if (!active_q) begin
         // Burst opens when the unit first asks for a beat
         if (req_i.valid) begin
            active_q <= 1'b1;
            base_q   <= req_i.addr;
            len_q    <= req_i.len;
            cnt_q    <= '0;
         end
      end else if (req_i.valid && rsp_o.ready) begin
         cnt_q <= cnt_q + LEN_W'(1);
         if (rsp_o.last) begin
            active_q <= 1'b0;
         end
      end
   end

   always_comb begin
      rsp_o.ready = active_q & ~stall_i;
      rsp_o.rdata = mem[idx];
      rsp_o.last  = (cnt_q == len_q - LEN_W'(1));
   end

endmodule

/* tb/lut_unit_tb.sv */
module lut_unit_tb
   import lut_pkg::*;
();

   localparam int DATA_W          = 32;
   localparam int ENTRY_W         = 16;
   localparam int TABLE_ADDR_W    = 8;
   localparam int LANES           = BUS_DATA_W / ENTRY_W;
   localparam int SEL_W           = (LANES > 1) ? $clog2(LANES) : 1;
   localparam int BUS_WORDS       = 512;
   localparam int TOTAL_BEATS     = 6 * 128;  // Linear, strided, three ping-pong, stalled
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 8 + 2000;
   localparam int DONE_TIMEOUT    = 128 * 8;

   logic              clk = 1'b0;
   logic              rst;
   logic              run_i;
   logic              disable_i;
   lut_cfg_t          cfg_i;
   logic [DATA_W-1:0] in_i;
   logic [DATA_W-1:0] out_o;
   logic              done_o;
   bus_req_t          bus_req;
   bus_rsp_t          bus_rsp;
   logic              stall;
   logic              stall_en;
   logic [31:0]       stall_bits;
   logic [15:0]       lfsr = 16'd91;
   logic [BUS_DATA_W-1:0] ref_tbl [2**TABLE_ADDR_W];  // Expected table contents
   logic              bank;      // Bank being loaded
   logic              cur_pp;
   logic              saw_last;  // Last beat transferred since the run
   int                errors;

   lut_unit_top #(
      .DATA_W      (DATA_W),
      .ENTRY_W     (ENTRY_W),
      .TABLE_ADDR_W(TABLE_ADDR_W)
   ) DUT (
      .clk      (clk),
      .rst      (rst),
      .run_i    (run_i),
      .disable_i(disable_i),
      .cfg_i    (cfg_i),
      .in_i     (in_i),
      .out_o    (out_o),
      .done_o   (done_o),
      .bus_req_o(bus_req),
      .bus_rsp_i(bus_rsp)
   );

   lut_bus_model #(
      .MEM_WORDS(BUS_WORDS)
   ) u_bus (
      .clk    (clk),
      .rst    (rst),
      .stall_i(stall),
      .req_i  (bus_req),
      .rsp_o  (bus_rsp)
   );

   always #20 clk = ~clk;

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      int i;
      val = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
   endtask

   always @(posedge clk) begin
      if (stall_en) begin
         take_bits(1, stall_bits);
         stall <= stall_bits[0];
      end else begin
         stall <= 1'b0;
      end
   end

   always @(posedge clk) begin
      if (bus_req.valid && bus_rsp.ready && bus_rsp.last) saw_last <= 1'b1;
   end

   task automatic check_entry(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   function automatic lut_cfg_t make_cfg(input int ext, input int iter, input int per,
                                         input int incr, input int shift, input logic pp);
      lut_cfg_t c;
      c.ext_addr  = BUS_ADDR_W'(ext);
      c.iter      = GEN_W'(iter);
      c.per       = GEN_W'(per);
      c.incr      = GEN_W'(incr);
      c.shift     = GEN_W'(shift);
      c.length    = LEN_W'(iter * per);
      c.ping_pong = pp;
      return c;
   endfunction

   // Word address from the upper bits, lane from the low bits
   function automatic logic [DATA_W-1:0] expect_lookup(input logic [DATA_W-1:0] x);
      logic [TABLE_ADDR_W-1:0] wa;
      logic [BUS_DATA_W-1:0]   word;
      wa = x[SEL_W +: TABLE_ADDR_W];
      if (cur_pp) wa[TABLE_ADDR_W-1] = ~bank;
      word = ref_tbl[wa];
      return DATA_W'(word[x[SEL_W-1:0] * ENTRY_W +: ENTRY_W]);
   endfunction

   task automatic start_run(input string name, input lut_cfg_t cfg, input logic dis);
      int k;
      int a;
      logic [TABLE_ADDR_W-1:0] wa;
      @(posedge clk);
      cfg_i     <= cfg;
      run_i     <= 1'b1;
      disable_i <= dis;
      @(posedge clk);
      run_i     <= 1'b0;
      disable_i <= 1'b0;
      saw_last = 1'b0;
      cur_pp   = cfg.ping_pong;
      bank     = cfg.ping_pong ? ~bank : 1'b0;  // Swaps on disabled runs too
      if (!dis) begin
         for (k = 0; k < cfg.iter * cfg.per; k++) begin
            a  = (k % cfg.per) * cfg.incr + (k / cfg.per) * cfg.shift;
            wa = a[TABLE_ADDR_W-1:0];
            if (cfg.ping_pong) wa[TABLE_ADDR_W-1] = bank;
            ref_tbl[wa] = u_bus.mem[(cfg.ext_addr + k) % BUS_WORDS];
         end
      end
      @(negedge clk);
      check_flag({name, " done_o after run"}, dis, done_o);
   endtask

   task automatic wait_done(input string name);
      int n;
      n = 0;
      while (done_o !== 1'b1 && n < DONE_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (done_o !== 1'b1) begin
         errors++;
         $display("Load in %s never finished, loader state %s", name,
                  DUT.u_reader.state_q.name());
      end
   endtask

   // Back-to-back lookups with each result checked three negedges after it is driven
   task automatic sweep_lookups(input string name, input int n_words);
      logic [DATA_W-1:0] exp_q[$];
      int total;
      int i;
      total = n_words * LANES;
      for (i = 0; i < total + 2; i++) begin
         @(posedge clk);
         if (i < total) begin
            in_i <= DATA_W'(i);
            exp_q.push_back(expect_lookup(DATA_W'(i)));
         end
         @(negedge clk);
         if (i >= 2) check_entry(name, exp_q.pop_front(), out_o);
      end
   endtask

   task automatic test_reset();
      check_flag("test_reset done_o", 1'b1, done_o);
      check_flag("test_reset bus valid", 1'b0, bus_req.valid);
   endtask

   task automatic test_linear_load();
      start_run("test_linear_load", make_cfg(0, 8, 16, 1, 16, 1'b0), 1'b0);
      wait_done("test_linear_load");
      sweep_lookups("test_linear_load", 128);
   endtask

   task automatic test_strided_load();
      start_run("test_strided_load", make_cfg(128, 2, 64, 2, 1, 1'b0), 1'b0);
      wait_done("test_strided_load");
      sweep_lookups("test_strided_load", 128);
   endtask

   task automatic test_ping_pong();
      start_run("test_ping_pong A", make_cfg(256, 8, 16, 1, 16, 1'b1), 1'b0);
      wait_done("test_ping_pong A");
      start_run("test_ping_pong B", make_cfg(384, 8, 16, 1, 16, 1'b1), 1'b0);
      sweep_lookups("test_ping_pong during B", 128);  // Overlaps the load
      wait_done("test_ping_pong B");
      sweep_lookups("test_ping_pong after B", 128);
      start_run("test_ping_pong C", make_cfg(0, 8, 16, 1, 16, 1'b1), 1'b0);
      sweep_lookups("test_ping_pong during C", 128);
      wait_done("test_ping_pong C");
   endtask

   task automatic test_disabled_run();
      start_run("test_disabled_run", make_cfg(128, 2, 64, 2, 1, 1'b0), 1'b1);
      repeat (20) begin
         @(negedge clk);
         check_flag("test_disabled_run done_o", 1'b1, done_o);
         check_flag("test_disabled_run bus valid", 1'b0, bus_req.valid);
      end
      sweep_lookups("test_disabled_run", 128);
   endtask

   task automatic test_stalled_load();
      stall_en = 1'b1;
      start_run("test_stalled_load", make_cfg(0, 8, 16, 1, 16, 1'b0), 1'b0);
      wait_done("test_stalled_load");
      check_flag("test_stalled_load last beat before done", 1'b1, saw_last);
      stall_en = 1'b0;
      sweep_lookups("test_stalled_load", 128);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
      $display("Error count: %0d", errors + 1);
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [31:0] w;
      int i;
      rst       = 1'b1;
      run_i     = 1'b0;
      disable_i = 1'b0;
      cfg_i     = '0;
      in_i      = '0;
      stall     = 1'b0;
      stall_en  = 1'b0;
      bank      = 1'b0;
      cur_pp    = 1'b0;
      saw_last  = 1'b0;
      errors    = 0;
      for (i = 0; i < BUS_WORDS; i++) begin
         take_bits(32, w);
         u_bus.mem[i] = w;
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      test_reset();
      test_linear_load();
      test_strided_load();
      test_ping_pong();
      test_disabled_run();
      test_stalled_load();
      $display("Error count: %0d", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* lut_unit.f */
rtl/lut_pkg.sv
rtl/lut_addr_gen.sv
rtl/lut_beat_join.sv
rtl/lut_lane_select.sv
rtl/lut_table_ram.sv
rtl/lut_reader.sv
rtl/lut_unit_top.sv
tb/lut_bus_model.sv
tb/lut_unit_tb.sv
